// File: Makefile
SRCS := $(wildcard source/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vsram_axi_bridge_tb: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module sram_axi_bridge_tb --Mdir obj_dir \
		-o Vsram_axi_bridge_tb -f sources.f

run: obj_dir/Vsram_axi_bridge_tb
	./obj_dir/Vsram_axi_bridge_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/sram_axi_bridge_tb.sv
module sram_axi_bridge_tb
  import sram_axi_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADDR_W        = 16;
  localparam int DATA_W        = 16;
  localparam int ID_W          = 4;
  localparam int WORD_W        = 15;
  localparam int FILL_MULT     = 32'h9e37;
  localparam int RANDOM_BURSTS = 20;
  // single 1+1, burst 8+8, strobe 4+4, random at most 8 beats each
  localparam int TOTAL_BEATS    = 2 + 16 + 8 + RANDOM_BURSTS * 8;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS * 6 + 200;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              last;
  } r_exp_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_exp_t;

  logic clk;
  logic rst_n;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_wlast;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic s_axi_rvalid, s_axi_rready, s_axi_rlast;
  logic [ID_W-1:0]   s_axi_awid, s_axi_bid, s_axi_arid, s_axi_rid;
  logic [ADDR_W-1:0] s_axi_awaddr, s_axi_araddr;
  logic [7:0]        s_axi_awlen, s_axi_arlen;
  logic [2:0]        s_axi_awsize, s_axi_arsize;
  logic [1:0]        s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
  logic [DATA_W-1:0] s_axi_wdata, s_axi_rdata;
  logic [DATA_W/8-1:0] s_axi_wstrb;
  logic [WORD_W-1:0] sram_io_addr;
  wire  [DATA_W-1:0] sram_io_data;
  logic sram_io_we_n, sram_io_oe_n, sram_io_ce_n;

  logic [DATA_W-1:0] exp_mem [int unsigned];  // words written with a full strobe
  r_exp_t r_exp_q [$];
  b_exp_t b_exp_q [$];
  r_exp_t r_item;
  b_exp_t b_item;
  int     r_beat;
  int     error_count, check_count, tests_run, test_start_errors, cycle_count;
  string  cur_test;
  logic   throttle;  // random holds on bready and rready

  sram_axi_bridge #(
    .AXI_ADDR_WIDTH(ADDR_W),
    .AXI_DATA_WIDTH(DATA_W),
    .AXI_ID_WIDTH  (ID_W),
    .FIFO_DEPTH    (4)
  ) i_sram_axi_bridge (.*);

  sram_model #(
    .ADDR_WIDTH(WORD_W),
    .DATA_WIDTH(DATA_W),
    .FILL_MULT (FILL_MULT)
  ) i_sram_model (
    .addr(sram_io_addr),
    .data(sram_io_data),
    .we_n(sram_io_we_n),
    .oe_n(sram_io_oe_n),
    .ce_n(sram_io_ce_n)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [DATA_W-1:0] expected_word(input int unsigned addr);
    if (exp_mem.exists(addr)) return exp_mem[addr];
    return DATA_W'(addr * FILL_MULT);  // power-up contents of the part
  endfunction

  task automatic report_problem(input string msg);
    $display("%s: %s", cur_test, msg);
    error_count++;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
    else begin
      $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    if (error_count == test_start_errors) $display("test %s done, no errors", cur_test);
    else $display("test %s done, %0d errors", cur_test, error_count - test_start_errors);
    tests_run++;
  endtask

  task automatic write_burst(input logic [ID_W-1:0] id, input int unsigned word,
                             input int len, input int bad_beat);
    logic [DATA_W-1:0] data;
    b_exp_t            item;
    item.id   = id;
    item.resp = (bad_beat >= 0 && bad_beat < len) ? axi_resp_slverr : axi_resp_okay;
    b_exp_q.push_back(item);
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b1;
    s_axi_awid    = id;
    s_axi_awaddr  = ADDR_W'(word * 2);
    s_axi_awlen   = 8'(len - 1);
    s_axi_awsize  = axi_size_from_width(DATA_W);
    s_axi_awburst = axi_burst_incr;
    @(negedge clk);
    while (!s_axi_awready) @(negedge clk);
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b0;
    for (int i = 0; i < len; i++) begin
      data         = DATA_W'($urandom);
      s_axi_wvalid = 1'b1;
      s_axi_wdata  = data;
      s_axi_wstrb  = (i == bad_beat) ? 2'b01 : 2'b11;
      s_axi_wlast  = (i == len - 1);
      @(negedge clk);
      while (!s_axi_wready) @(negedge clk);
      @(posedge clk);
      #1;
      if (i != bad_beat) exp_mem[word + i] = data;  // partial strobe leaves the word as it was
    end
    s_axi_wvalid = 1'b0;
    s_axi_wlast  = 1'b0;
    while (b_exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic read_burst(input logic [ID_W-1:0] id, input int unsigned word, input int len);
    r_exp_t item;
    for (int i = 0; i < len; i++) begin
      item.id   = id;
      item.data = expected_word(word + i);
      item.last = (i == len - 1);
      r_exp_q.push_back(item);
    end
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b1;
    s_axi_arid    = id;
    s_axi_araddr  = ADDR_W'(word * 2);
    s_axi_arlen   = 8'(len - 1);
    s_axi_arsize  = axi_size_from_width(DATA_W);
    s_axi_arburst = axi_burst_incr;
    @(negedge clk);
    while (!s_axi_arready) @(negedge clk);
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b0;
    while (r_exp_q.size() != 0) @(negedge clk);
  endtask

  // transfers are sampled mid-cycle, the edge after this one completes them
  always @(negedge clk) begin
    if (rst_n && s_axi_rvalid && s_axi_rready) begin
      assert (r_exp_q.size() != 0) else report_problem("R beat arrived with no read outstanding");
      if (r_exp_q.size() != 0) begin
        r_item = r_exp_q.pop_front();
        check_value($sformatf("rid beat %0d", r_beat), r_item.id, s_axi_rid);
        check_value($sformatf("rdata beat %0d", r_beat), r_item.data, s_axi_rdata);
        check_value($sformatf("rlast beat %0d", r_beat), r_item.last, s_axi_rlast);
        check_value($sformatf("rresp beat %0d", r_beat), axi_resp_okay, s_axi_rresp);
        r_beat = r_item.last ? 0 : r_beat + 1;
      end
    end
    if (rst_n && s_axi_bvalid && s_axi_bready) begin
      assert (b_exp_q.size() != 0) else report_problem("B arrived with no write outstanding");
      if (b_exp_q.size() != 0) begin
        b_item = b_exp_q.pop_front();
        check_value("bid", b_item.id, s_axi_bid);
        check_value("bresp", b_item.resp, s_axi_bresp);
      end
    end
  end

  initial begin : ready_driver
    int span;
    forever begin
      @(posedge clk);
      #1;
      if (throttle && $urandom_range(0, 3) == 0) begin
        span         = $urandom_range(1, 8);
        s_axi_bready = 1'b0;
        s_axi_rready = 1'b0;
        repeat (span) @(posedge clk);
        #1;
      end
      s_axi_bready = 1'b1;
      s_axi_rready = 1'b1;
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int               len;
    int unsigned      word;
    logic [ID_W-1:0]  id;
    int               wait_cycles;
    void'($urandom(32'h230c6224));
    rst_n = 1'b0;
    throttle = 1'b0;
    {s_axi_awvalid, s_axi_awid, s_axi_awaddr, s_axi_awlen, s_axi_awsize, s_axi_awburst} = '0;
    {s_axi_wvalid, s_axi_wdata, s_axi_wstrb, s_axi_wlast, s_axi_bready} = '0;
    {s_axi_arvalid, s_axi_arid, s_axi_araddr, s_axi_arlen, s_axi_arsize, s_axi_arburst} = '0;
    s_axi_rready = 1'b0;
    {error_count, check_count, tests_run, r_beat} = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    begin_test("reset");
    @(negedge clk);
    check_value("bvalid", 0, s_axi_bvalid);
    check_value("rvalid", 0, s_axi_rvalid);
    check_value("ce_n", 1, sram_io_ce_n);
    wait_cycles = 0;
    while (!(s_axi_awready && s_axi_arready) && wait_cycles < 10) begin
      @(negedge clk);
      wait_cycles++;
    end
    assert (s_axi_awready && s_axi_arready)
    else report_problem("awready and arready did not rise after reset");
    end_test();

    begin_test("single_beat");
    write_burst(4'h3, 32'h10, 1, -1);
    read_burst(4'h5, 32'h10, 1);
    end_test();

    begin_test("incr_burst8");
    write_burst(4'h7, 32'h20, 8, -1);
    read_burst(4'h8, 32'h20, 8);
    end_test();

    begin_test("partial_strobe");
    write_burst(4'h9, 32'h20, 4, 1);  // second beat has one lane off
    read_burst(4'ha, 32'h20, 4);
    end_test();

    begin_test("random_bursts");
    throttle = 1'b1;
    for (int n = 0; n < RANDOM_BURSTS; n++) begin
      len  = $urandom_range(1, 8);
      word = $urandom_range(0, 7) * 8 + $urandom_range(0, 8 - len);  // small window, reads hit writes
      id   = ID_W'($urandom);
      if ($urandom_range(0, 1) == 1) write_burst(id, word, len, -1);
      else read_burst(id, word, len);
    end
    throttle = 1'b0;
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/sram_model.sv
module sram_model #(
  parameter int ADDR_WIDTH = 15,
  parameter int DATA_WIDTH = 16,
  parameter int FILL_MULT  = 32'h9e37
) (
  input  logic [ADDR_WIDTH-1:0] addr,
  inout  wire  [DATA_WIDTH-1:0] data,
  input  logic                  we_n,
  input  logic                  oe_n,
  input  logic                  ce_n
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
  logic                  write_open;  // we_n fell since the last write

  initial begin
    write_open = 1'b0;
    for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
      mem[i] = DATA_WIDTH'(i * FILL_MULT);  // odd multiplier, every word differs
    end
  end

  // bus is driven only for a read with we_n high
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

  always @(negedge we_n) write_open = 1'b1;

  // the word is taken on the rising edge of we_n
  always @(posedge we_n) begin
    if (write_open && !ce_n) mem[addr] = data;
    write_open = 1'b0;
  end

endmodule

// File: source/sram_axi_bridge.sv
module sram_axi_bridge
  import sram_io_pkg::*;
  import sram_axi_pkg::*;
#(
  parameter int AXI_ADDR_WIDTH = 16,
  parameter int AXI_DATA_WIDTH = 16,
  parameter int AXI_ID_WIDTH   = 4,
  parameter int FIFO_DEPTH     = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [AXI_ID_WIDTH-1:0]     s_axi_awid,
  input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic [7:0]                  s_axi_awlen,
  input  logic [2:0]                  s_axi_awsize,
  input  logic [1:0]                  s_axi_awburst,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  input  logic [AXI_DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                        s_axi_wlast,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  output logic [AXI_ID_WIDTH-1:0]     s_axi_bid,
  output logic [1:0]                  s_axi_bresp,

  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  input  logic [AXI_ID_WIDTH-1:0]     s_axi_arid,
  input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic [7:0]                  s_axi_arlen,
  input  logic [2:0]                  s_axi_arsize,
  input  logic [1:0]                  s_axi_arburst,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,
  output logic [AXI_ID_WIDTH-1:0]     s_axi_rid,
  output logic [AXI_DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rlast,

  output logic [AXI_ADDR_WIDTH-int'(axi_size_from_width(AXI_DATA_WIDTH))-1:0] sram_io_addr,
  inout  wire  [AXI_DATA_WIDTH-1:0]   sram_io_data,
  output logic                        sram_io_we_n,
  output logic                        sram_io_oe_n,
  output logic                        sram_io_ce_n
);

  // one SRAM word per AXI beat
  localparam int SRAM_ADDR_WIDTH = AXI_ADDR_WIDTH - int'(axi_size_from_width(AXI_DATA_WIDTH));

  typedef struct packed {
    sram_op_e                   op;
    logic [SRAM_ADDR_WIDTH-1:0] addr;  // word address
    logic [AXI_DATA_WIDTH-1:0]  data;
    logic [AXI_ID_WIDTH-1:0]    id;
    logic                       last;
  } req_t;

  typedef struct packed {
    logic                      is_write;
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [1:0]                resp;
    logic                      last;
  } rsp_t;

  req_t front_req;
  logic front_req_valid;
  logic front_req_ready;
  req_t ctrl_req;
  logic ctrl_req_valid;
  logic ctrl_req_ready;
  rsp_t ctrl_rsp;
  logic ctrl_rsp_valid;
  logic ctrl_rsp_ready;
  rsp_t front_rsp;
  logic front_rsp_valid;
  logic front_rsp_ready;

  // AXI ports and clk/rst_n connect by name
  sram_burst_front #(
    .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
    .AXI_ID_WIDTH   (AXI_ID_WIDTH),
    .SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .req_t          (req_t),
    .rsp_t          (rsp_t)
  ) i_burst_front (
    .*,
    .req_data (front_req),
    .req_valid(front_req_valid),
    .req_ready(front_req_ready),
    .rsp_data (front_rsp),
    .rsp_valid(front_rsp_valid),
    .rsp_ready(front_rsp_ready)
  );

  sram_fifo #(
    .item_t(req_t),
    .DEPTH (FIFO_DEPTH)
  ) i_req_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_data (front_req),
    .push_valid(front_req_valid),
    .push_ready(front_req_ready),
    .pop_data  (ctrl_req),
    .pop_valid (ctrl_req_valid),
    .pop_ready (ctrl_req_ready)
  );

  sram_fifo #(
    .item_t(rsp_t),
    .DEPTH (FIFO_DEPTH)
  ) i_rsp_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_data (ctrl_rsp),
    .push_valid(ctrl_rsp_valid),
    .push_ready(ctrl_rsp_ready),
    .pop_data  (front_rsp),
    .pop_valid (front_rsp_valid),
    .pop_ready (front_rsp_ready)
  );

  // sram_io pins and clk/rst_n connect by name
  sram_pin_ctrl #(
    .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
    .SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .req_t          (req_t),
    .rsp_t          (rsp_t)
  ) i_pin_ctrl (
    .*,
    .req_data (ctrl_req),
    .req_valid(ctrl_req_valid),
    .req_ready(ctrl_req_ready),
    .rsp_data (ctrl_rsp),
    .rsp_valid(ctrl_rsp_valid),
    .rsp_ready(ctrl_rsp_ready)
  );

endmodule

// File: source/sram_axi_pkg.sv
package sram_axi_pkg;

  // xRESP codes returned on B and R
  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

  // only INCR is generated by masters here, other burst types run as INCR
  localparam logic [1:0] axi_burst_incr = 2'b01;

  // AxSIZE code for a beat that fills the whole data bus,
  // also the number of byte offset bits in an address
  function automatic logic [2:0] axi_size_from_width(input int width);
    int bytes;
    int size;
    bytes = width / 8;
    size  = 0;
    while ((1 << size) < bytes) begin
      size++;
    end
    return 3'(size);
  endfunction

endpackage

// File: source/sram_burst_front.sv
module sram_burst_front
  import sram_io_pkg::*;
  import sram_axi_pkg::*;
#(
  parameter int  AXI_ADDR_WIDTH  = 16,
  parameter int  AXI_DATA_WIDTH  = 16,
  parameter int  AXI_ID_WIDTH    = 4,
  parameter int  SRAM_ADDR_WIDTH = 15,
  parameter type req_t           = logic,
  parameter type rsp_t           = logic
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      s_axi_awvalid,
  output logic                      s_axi_awready,
  input  logic [AXI_ID_WIDTH-1:0]   s_axi_awid,
  input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic [7:0]                s_axi_awlen,
  input  logic [2:0]                s_axi_awsize,
  input  logic [1:0]                s_axi_awburst,
  input  logic                      s_axi_wvalid,
  output logic                      s_axi_wready,
  input  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                      s_axi_wlast,
  output logic                      s_axi_bvalid,
  input  logic                      s_axi_bready,
  output logic [AXI_ID_WIDTH-1:0]   s_axi_bid,
  output logic [1:0]                s_axi_bresp,

  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,
  input  logic [AXI_ID_WIDTH-1:0]   s_axi_arid,
  input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic [7:0]                s_axi_arlen,
  input  logic [2:0]                s_axi_arsize,
  input  logic [1:0]                s_axi_arburst,
  output logic                      s_axi_rvalid,
  input  logic                      s_axi_rready,
  output logic [AXI_ID_WIDTH-1:0]   s_axi_rid,
  output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rlast,

  output req_t                      req_data,
  output logic                      req_valid,
  input  logic                      req_ready,

  input  rsp_t                      rsp_data,
  input  logic                      rsp_valid,
  output logic                      rsp_ready
);

  // byte offset bits below the word address
  localparam int ADDR_LSB = int'(axi_size_from_width(AXI_DATA_WIDTH));

  logic                       started;
  logic                       active;
  logic                       is_write;
  logic                       prefer_rd;
  logic [AXI_ID_WIDTH-1:0]    cur_id;
  logic [SRAM_ADDR_WIDTH-1:0] cur_addr;
  logic [7:0]                 beats_left;  // beats after the current one
  logic                       idle;
  logic                       aw_fire;
  logic                       ar_fire;
  logic                       push;
  logic                       req_last;

  assign idle = started && !active;

  // alternate priority when AW and AR are both waiting
  assign s_axi_awready = idle && !(s_axi_arvalid && prefer_rd);
  assign s_axi_arready = idle && !(s_axi_awvalid && !prefer_rd);

  assign aw_fire  = s_axi_awvalid && s_axi_awready;
  assign ar_fire  = s_axi_arvalid && s_axi_arready;
  assign req_last = (beats_left == 8'd0);

  // write beats need W data, read beats only need room in the FIFO
  assign req_valid    = active && (!is_write || s_axi_wvalid);
  assign s_axi_wready = active && is_write && req_ready;
  assign push         = req_valid && req_ready;

  always_comb begin
    req_data = '0;
    if (!is_write) req_data.op = sram_op_read;
    else if (&s_axi_wstrb) req_data.op = sram_op_write;
    else req_data.op = sram_op_skip;  // no byte lanes on the part
    req_data.addr = cur_addr;
    req_data.data = is_write ? s_axi_wdata : '0;
    req_data.id   = cur_id;
    req_data.last = req_last;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started   <= 1'b0;
      active    <= 1'b0;
      is_write  <= 1'b0;
      prefer_rd <= 1'b0;
    end else begin
      started <= 1'b1;
      if (aw_fire) begin
        active    <= 1'b1;
        is_write  <= 1'b1;
        prefer_rd <= 1'b1;
      end else if (ar_fire) begin
        active    <= 1'b1;
        is_write  <= 1'b0;
        prefer_rd <= 1'b0;
      end else if (push && req_last) begin
        active <= 1'b0;
      end
    end
  end

  // burst and size are not decoded, every burst walks up one word per beat
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      cur_id     <= s_axi_awid;
      cur_addr   <= s_axi_awaddr[ADDR_LSB +: SRAM_ADDR_WIDTH];
      beats_left <= s_axi_awlen;
    end else if (ar_fire) begin
      cur_id     <= s_axi_arid;
      cur_addr   <= s_axi_araddr[ADDR_LSB +: SRAM_ADDR_WIDTH];
      beats_left <= s_axi_arlen;
    end else if (push) begin
      cur_addr   <= cur_addr + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

  // response items go to B or R by their write flag
  assign s_axi_bvalid = rsp_valid && rsp_data.is_write;
  assign s_axi_bid    = rsp_data.id;
  assign s_axi_bresp  = rsp_data.resp;

  assign s_axi_rvalid = rsp_valid && !rsp_data.is_write;
  assign s_axi_rid    = rsp_data.id;
  assign s_axi_rdata  = rsp_data.data;
  assign s_axi_rresp  = rsp_data.resp;
  assign s_axi_rlast  = rsp_data.last;

  assign rsp_ready = rsp_data.is_write ? s_axi_bready : s_axi_rready;

endmodule

// File: source/sram_fifo.sv
module sram_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 4
) (
  input  logic  clk,
  input  logic  rst_n,

  input  item_t push_data,
  input  logic  push_valid,
  output logic  push_ready,

  output item_t pop_data,
  output logic  pop_valid,
  input  logic  pop_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign push_ready = (count != FULL_COUNT);
  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];

  assign push = push_valid && push_ready;
  assign pop  = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, pointers wrap
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

endmodule

// File: source/sram_io_pkg.sv
package sram_io_pkg;

  // what the pin controller does with one request item
  typedef enum logic [1:0] {
    sram_op_write = 2'b00,  // write one word
    sram_op_read  = 2'b01,  // read one word
    sram_op_skip  = 2'b10   // partial strobe, pins stay idle
  } sram_op_e;

endpackage

// File: source/sram_pin_ctrl.sv
module sram_pin_ctrl
  import sram_io_pkg::*;
  import sram_axi_pkg::*;
#(
  parameter int  AXI_DATA_WIDTH  = 16,
  parameter int  SRAM_ADDR_WIDTH = 15,
  parameter type req_t           = logic,
  parameter type rsp_t           = logic
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  req_t                       req_data,
  input  logic                       req_valid,
  output logic                       req_ready,

  output rsp_t                       rsp_data,
  output logic                       rsp_valid,
  input  logic                       rsp_ready,

  output logic [SRAM_ADDR_WIDTH-1:0] sram_io_addr,
  inout  wire  [AXI_DATA_WIDTH-1:0]  sram_io_data,
  output logic                       sram_io_we_n,
  output logic                       sram_io_oe_n,
  output logic                       sram_io_ce_n
);

  typedef enum logic [1:0] {
    st_idle,
    st_phase1,
    st_phase2
  } state_e;

  state_e state;
  req_t   cur;
  logic   drive;
  logic   err_flag;  // a skipped beat earlier in this write burst
  logic   pop;

  // only this block fills the response FIFO, so room seen now is still there in phase two
  assign req_ready = (state == st_idle) && rsp_ready;
  assign pop       = req_valid && req_ready;

  assign rsp_valid    = (state == st_phase2) && (cur.op == sram_op_read || cur.last);
  assign sram_io_addr = cur.addr;
  assign sram_io_data = drive ? cur.data : 'z;

  always_comb begin
    rsp_data          = '0;
    rsp_data.is_write = (cur.op != sram_op_read);
    rsp_data.id       = cur.id;
    rsp_data.data     = (cur.op == sram_op_read) ? sram_io_data : '0;  // latched by the FIFO
    rsp_data.last     = cur.last;
    rsp_data.resp     = axi_resp_okay;
    if (cur.op != sram_op_read && (err_flag || cur.op == sram_op_skip)) begin
      rsp_data.resp = axi_resp_slverr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= st_idle;
      drive        <= 1'b0;
      err_flag     <= 1'b0;
      sram_io_ce_n <= 1'b1;
      sram_io_we_n <= 1'b1;
      sram_io_oe_n <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (pop) begin
            state        <= st_phase1;
            sram_io_ce_n <= (req_data.op == sram_op_skip);
            sram_io_we_n <= (req_data.op != sram_op_write);
            sram_io_oe_n <= (req_data.op != sram_op_read);
            drive        <= (req_data.op == sram_op_write);
          end
        end
        st_phase1: begin
          state        <= st_phase2;
          sram_io_we_n <= 1'b1;  // rising we_n ends the write, data still held
        end
        st_phase2: begin
          if (!rsp_valid || rsp_ready) begin
            state        <= st_idle;
            sram_io_ce_n <= 1'b1;
            sram_io_oe_n <= 1'b1;
            drive        <= 1'b0;
            if (cur.last) err_flag <= 1'b0;
            else if (cur.op == sram_op_skip) err_flag <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) cur <= req_data;
  end

endmodule

// File: sources.f
source/sram_axi_pkg.sv
source/sram_io_pkg.sv
source/sram_fifo.sv
source/sram_burst_front.sv
source/sram_pin_ctrl.sv
source/sram_axi_bridge.sv
sim/sram_model.sv
sim/sram_axi_bridge_tb.sv
